// ==== list.f ====
design/bp_pkg.sv
design/btb.sv
design/fetch_pc_gen.sv
design/fetch_queue.sv
design/branch_resolve.sv
design/predict_top.sv
bench/predict_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the predictor testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module predict_tb -o predict_sim

out=$(./obj_dir/predict_sim)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

// ==== bench/predict_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// walks a branch trace through predict_top with random outcome gaps
// the branch layout keeps wrong-path fetches away from the set 8 branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module predict_tb;
	import bp_pkg::*;

	localparam int IDLE_LIMIT = 60;	// cycles allowed without a commit
	localparam int TAIL_COMMITS = 4;	// plain commits after the last branch

	logic CLK, nRST;
	logic res_valid, res_is_branch, res_taken;
	word_t res_target;
	logic res_ready, commit_valid, commit_mispredict;
	word_t commit_pc;

	// program order branch trace; any other PC is a plain instruction
	word_t tr_pc [$];
	logic tr_taken [$];
	word_t tr_target [$];
	// branches the BTB should hold and the commit count of their last use
	word_t lrn_pc [$];
	logic lrn_taken [$];
	word_t lrn_target [$];
	int lrn_stamp [$];

	word_t exp_pc, exp_next;	// expected commit and its real successor
	logic exp_mis, accepted, timed_out;
	string test_name;
	int seed = 58851;
	int pc_errs, mis_errs, hs_errs, other_errs;
	int tr_idx, n_commits, tail, idle;

	predict_top uut (
		.CLK, .nRST,
		.res_valid, .res_is_branch, .res_taken, .res_target, .res_ready,
		.commit_valid, .commit_pc, .commit_mispredict
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	a_handshake: assert property (@(posedge CLK) disable iff (!nRST)
		commit_valid == (res_valid && res_ready))
		else begin
			hs_errs++;
			$display("mismatch %s: commit_valid expected %b actual %b", test_name,
				$sampled(res_valid && res_ready), $sampled(commit_valid));
		end

	a_order: assert property (@(posedge CLK) disable iff (!nRST)
		commit_valid |-> commit_pc == exp_pc)
		else begin
			pc_errs++;
			$display("mismatch %s: commit_pc expected %h actual %h", test_name,
				$sampled(exp_pc), $sampled(commit_pc));
		end

	a_predict: assert property (@(posedge CLK) disable iff (!nRST)
		commit_valid |-> commit_mispredict == exp_mis)
		else begin
			mis_errs++;
			$display("mismatch %s: commit_mispredict at %h expected %b actual %b",
				test_name, $sampled(exp_pc), $sampled(exp_mis), $sampled(commit_mispredict));
		end

	task automatic add_branch(word_t pc, logic taken, word_t target);
		tr_pc.push_back(pc);
		tr_taken.push_back(taken);
		tr_target.push_back(target);
	endtask

	task automatic load_program();
		// loop over 0x100..0x10c where N is never taken and L is taken 3 times then falls out
		for (int n = 0; n < 4; n++) begin
			add_branch(32'h0000_0104, 1'b0, 32'h0000_0100);
			add_branch(32'h0000_010c, n < 3, 32'h0000_0100);
		end
		add_branch(32'h0000_0114, 1'b1, 32'h0000_0420);	// into the A/B/C area
		// A=0x420 B=0x820 C=0xc20 share set 8 and E at 0x600 picks the path
		add_branch(32'h0000_0420, 1'b1, 32'h0000_0600);	// A
		add_branch(32'h0000_0600, 1'b0, 32'h0000_0680);
		add_branch(32'h0000_0630, 1'b1, 32'h0000_0820);
		add_branch(32'h0000_0820, 1'b1, 32'h0000_0420);	// B
		add_branch(32'h0000_0420, 1'b1, 32'h0000_0600);	// A hits
		add_branch(32'h0000_0600, 1'b1, 32'h0000_0680);
		add_branch(32'h0000_06b0, 1'b1, 32'h0000_0c20);
		add_branch(32'h0000_0c20, 1'b1, 32'h0000_0420);	// C evicts B
		add_branch(32'h0000_0420, 1'b1, 32'h0000_0600);	// A hits again
		add_branch(32'h0000_0600, 1'b0, 32'h0000_0680);
		add_branch(32'h0000_0630, 1'b1, 32'h0000_0820);
		add_branch(32'h0000_0820, 1'b1, 32'h0000_0420);	// B returns cold
		add_branch(32'h0000_0420, 1'b1, 32'h0000_0600);
	endtask

	function automatic int find_learned(word_t pc);
		for (int i = 0; i < lrn_pc.size(); i++)
			if (lrn_pc[i] == pc)
				return i;
		return -1;
	endfunction

	// next PC that a 1-bit BTB with the learned state would fetch
	function automatic word_t predicted_next(word_t pc);
		int i;
		i = find_learned(pc);
		if (i >= 0 && lrn_taken[i])
			return lrn_target[i];
		return pc + 32'd4;	// miss or not taken
	endfunction

	// a cold branch in a full set replaces the least recently used one
	task automatic learn_branch(word_t pc, logic taken, word_t target);
		int i;
		int in_set;
		int oldest;
		i = find_learned(pc);
		if (i < 0) begin
			in_set = 0;
			oldest = -1;
			for (int k = 0; k < lrn_pc.size(); k++) begin
				if (lrn_pc[k][N_SET_BITS+1:2] == pc[N_SET_BITS+1:2]) begin
					in_set++;
					if (oldest < 0 || lrn_stamp[k] < lrn_stamp[oldest])
						oldest = k;
				end
			end
			if (in_set < ASSOC) begin
				lrn_pc.push_back(pc);
				lrn_taken.push_back(1'b0);
				lrn_target.push_back('0);
				lrn_stamp.push_back(0);
				i = lrn_pc.size() - 1;
			end else begin
				i = oldest;
				lrn_pc[i] = pc;
			end
		end
		lrn_taken[i] = taken;
		lrn_target[i] = target;
		lrn_stamp[i] = n_commits;
	endtask

	// outcome for the oldest fetch offered on a random subset of cycles
	task automatic drive_outcome();
		logic is_br;
		is_br = 1'b0;
		if (tr_idx < tr_pc.size())
			is_br = (tr_pc[tr_idx] == exp_pc);
		res_valid = ($random(seed) % 4 != 0);	// about 3 in 4
		res_is_branch = is_br;
		if (is_br) begin
			res_taken = tr_taken[tr_idx];
			res_target = tr_target[tr_idx];
		end else begin
			res_taken = 1'b0;
			res_target = '0;
		end
		exp_next = res_taken ? res_target : exp_pc + 32'd4;
		exp_mis = (exp_next != predicted_next(exp_pc));
		accepted = res_valid && res_ready;	// empty queue ignores the outcome
		if (n_commits == 0)
			test_name = "reset_state";
		else if (tr_idx < 8)
			test_name = "learned_branch";
		else
			test_name = "replacement";
	endtask

	task automatic retire_model();
		if (res_is_branch) begin
			learn_branch(exp_pc, res_taken, res_target);
			tr_idx++;
		end
		exp_pc = exp_next;
		n_commits++;
		if (tr_idx >= tr_pc.size())
			tail++;
	endtask

	initial begin
		nRST = 1'b0;
		res_valid = 1'b0;
		res_is_branch = 1'b0;
		res_taken = 1'b0;
		res_target = '0;
		exp_pc = RESET_PC;	// first commit is the reset fetch
		exp_next = RESET_PC;
		exp_mis = 1'b0;
		accepted = 1'b0;
		timed_out = 1'b0;
		test_name = "reset_state";
		load_program();
		repeat (2) @(posedge CLK);
		#1;
		nRST = 1'b1;
		// queue stays empty until the first push lands on the next edge
		assert (!res_ready)
			else begin
				other_errs++;
				$display("mismatch reset_state: res_ready expected 0 actual %b", res_ready);
			end
		assert (!commit_valid)
			else begin
				other_errs++;
				$display("mismatch reset_state: commit_valid expected 0 actual %b",
					commit_valid);
			end
		while (tail < TAIL_COMMITS && !timed_out) begin
			@(posedge CLK);
			#1;
			if (accepted) begin
				retire_model();
				idle = 0;
			end else begin
				idle++;
			end
			if (idle > IDLE_LIMIT) begin
				other_errs++;
				timed_out = 1'b1;
				$display("timeout: no commit for %0d cycles, waiting for pc %h",
					IDLE_LIMIT, exp_pc);
			end else begin
				drive_outcome();
			end
		end
		$display("errors: commit_pc %0d, mispredict %0d, handshake %0d, other %0d",
			pc_errs, mis_errs, hs_errs, other_errs);
		if (pc_errs + mis_errs + hs_errs + other_errs == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== design/predict_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// next-PC prediction front end: sequencer, BTB, fetch queue, resolver
// outcomes are accepted only while res_ready is high, oldest fetch first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module predict_top (
	input logic CLK, nRST,
	input logic res_valid, res_is_branch, res_taken,
	input bp_pkg::word_t res_target,
	output logic res_ready,
	output logic commit_valid,
	output bp_pkg::word_t commit_pc,
	output logic commit_mispredict
);
	import bp_pkg::*;

	// sequencer <-> BTB
	word_t lookup_pc, pred_target;
	logic pred_taken;

	// sequencer -> queue
	logic push_valid, push_ready, push_taken;
	word_t push_pc, push_target;

	// queue -> resolver
	logic head_valid, head_ready;
	word_t head_pc, head_target;

	// resolver -> BTB, sequencer and queue
	logic upd_valid, upd_taken, redirect_valid;
	word_t upd_pc, upd_target, redirect_pc;

	assign res_ready = head_valid;	// outcome only meaningful with a head

	fetch_pc_gen u_pc_gen (
		.CLK, .nRST,
		.lookup_pc, .pred_taken, .pred_target,
		.push_valid, .push_ready, .push_pc, .push_taken, .push_target,
		.redirect_valid, .redirect_pc
	);

	btb u_btb (
		.CLK, .nRST,
		.lookup_pc, .pred_taken, .pred_target,
		.upd_valid, .upd_pc, .upd_taken, .upd_target
	);

	fetch_queue u_queue (
		.CLK, .nRST,
		.flush(redirect_valid),	// mispredict empties the queue
		.push_valid, .push_ready, .push_pc, .push_taken, .push_target,
		.head_valid, .head_ready, .head_pc,
		.head_taken(),	// resolver judges on target only
		.head_target
	);

	branch_resolve u_resolve (
		.head_valid, .head_ready, .head_pc, .head_target,
		.res_valid, .res_is_branch, .res_taken, .res_target,
		.upd_valid, .upd_pc, .upd_taken, .upd_target,
		.redirect_valid, .redirect_pc,
		.commit_valid, .commit_pc, .commit_mispredict
	);

endmodule

// ==== design/branch_resolve.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pairs the oldest fetch with its real outcome, purely combinational
// an outcome always belongs to the queue head; mispredict is judged
// on the predicted next PC alone, not on the direction bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module branch_resolve (
	input logic head_valid,
	output logic head_ready,
	input bp_pkg::word_t head_pc,
	input bp_pkg::word_t head_target,
	input logic res_valid,
	input logic res_is_branch,
	input logic res_taken,
	input bp_pkg::word_t res_target,
	output logic upd_valid,
	output bp_pkg::word_t upd_pc,
	output logic upd_taken,
	output bp_pkg::word_t upd_target,
	output logic redirect_valid,
	output bp_pkg::word_t redirect_pc,
	output logic commit_valid,
	output bp_pkg::word_t commit_pc,
	output logic commit_mispredict
);
	import bp_pkg::*;

	logic accept;	// outcome consumed this cycle
	word_t actual_next;
	logic wrong_next;

	assign head_ready = res_valid;
	assign accept = head_valid && res_valid;

	// where the program really goes after the head
	assign actual_next = (res_is_branch && res_taken) ? res_target
		: head_pc + INSTR_BYTES;
	assign wrong_next = (actual_next != head_target);

	// train the BTB on branches only
	assign upd_valid = accept && res_is_branch;
	assign upd_pc = head_pc;
	assign upd_taken = res_taken;
	assign upd_target = res_target;

	// wrong path: flush queue, restart sequencer
	assign redirect_valid = accept && wrong_next;
	assign redirect_pc = actual_next;

	// retire report
	assign commit_valid = accept;
	assign commit_pc = head_pc;
	assign commit_mispredict = accept && wrong_next;

endmodule

// ==== design/fetch_queue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular FIFO of predicted fetches, push and pop allowed together
// pointers wrap naturally, so QUEUE_DEPTH must be a power of two
// flush drops every entry, including a push on the same edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fetch_queue (
	input logic CLK, nRST,
	input logic flush,
	input logic push_valid,
	output logic push_ready,
	input bp_pkg::word_t push_pc,
	input logic push_taken,
	input bp_pkg::word_t push_target,
	output logic head_valid,
	input logic head_ready,
	output bp_pkg::word_t head_pc,
	output logic head_taken,
	output bp_pkg::word_t head_target
);
	import bp_pkg::*;

	word_t pc_q [QUEUE_DEPTH];
	logic taken_q [QUEUE_DEPTH];
	word_t target_q [QUEUE_DEPTH];

	logic [QUEUE_PTR_BITS-1:0] wr_ptr, rd_ptr;
	logic [QUEUE_CNT_BITS-1:0] count;
	logic do_push, do_pop;

	assign push_ready = (count != QUEUE_CNT_BITS'(QUEUE_DEPTH));	// not full
	assign head_valid = (count != '0);
	assign do_push = push_valid && push_ready;
	assign do_pop = head_valid && head_ready;

	// head entry read straight out of storage
	assign head_pc = pc_q[rd_ptr];
	assign head_taken = taken_q[rd_ptr];
	assign head_target = target_q[rd_ptr];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;	// wrong path, start over
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// count moves only when exactly one side fires
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// payload, a flushed write is just never read
	always_ff @(posedge CLK) begin
		if (do_push) begin
			pc_q[wr_ptr] <= push_pc;
			taken_q[wr_ptr] <= push_taken;
			target_q[wr_ptr] <= push_target;
		end
	end

endmodule

// ==== design/fetch_pc_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch PC sequencer, one fetch offered every cycle
// holds its PC while the queue is full; a redirect beats the advance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fetch_pc_gen (
	input logic CLK, nRST,
	output bp_pkg::word_t lookup_pc,
	input logic pred_taken,
	input bp_pkg::word_t pred_target,
	output logic push_valid,
	input logic push_ready,
	output bp_pkg::word_t push_pc,
	output logic push_taken,
	output bp_pkg::word_t push_target,
	input logic redirect_valid,
	input bp_pkg::word_t redirect_pc
);
	import bp_pkg::*;

	pc_view_t fetch_pc;	// current fetch address

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			fetch_pc.raw <= RESET_PC;
		end else if (redirect_valid) begin
			fetch_pc.raw <= redirect_pc;	// resolver knows better
		end else if (push_valid && push_ready) begin
			fetch_pc.raw <= pred_target;	// follow the BTB
		end
	end

	assign lookup_pc = fetch_pc.raw;

	// every cycle is a fetch, the queue decides when it lands
	assign push_valid = 1'b1;
	assign push_pc = fetch_pc.raw;
	assign push_taken = pred_taken;
	assign push_target = pred_target;	// prediction travels with the entry

endmodule

// ==== design/btb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2-way set associative branch target buffer, 16 sets, 1-bit direction
// lookup is combinational; an update is seen by lookups the next cycle
// a lookup miss never allocates, only the update port writes frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module btb (
	input logic CLK, nRST,
	input bp_pkg::word_t lookup_pc,
	output logic pred_taken,
	output bp_pkg::word_t pred_target,
	input logic upd_valid,
	input bp_pkg::word_t upd_pc,
	input logic upd_taken,
	input bp_pkg::word_t upd_target
);
	import bp_pkg::*;

	// frame storage, split per field
	logic [ASSOC-1:0] valid_q [N_SETS];
	logic lru_q [N_SETS];	// way to evict next
	logic [N_TAG_BITS-1:0] tag_q [N_SETS][ASSOC];
	word_t target_q [N_SETS][ASSOC];
	logic taken_q [N_SETS][ASSOC];

	pc_view_t lk_pc, up_pc;
	logic [ASSOC-1:0] lk_hit, up_hit;
	logic lk_way;	// matching way on lookup
	logic up_way;	// way written by update

	assign lk_pc.raw = lookup_pc;
	assign up_pc.raw = upd_pc;

	// tag compare, both ways of both selected sets
	always_comb begin
		for (int w = 0; w < ASSOC; w++) begin
			lk_hit[w] = valid_q[lk_pc.fields.idx_bits][w] &&
				(tag_q[lk_pc.fields.idx_bits][w] == lk_pc.fields.tag_bits);
			up_hit[w] = valid_q[up_pc.fields.idx_bits][w] &&
				(tag_q[up_pc.fields.idx_bits][w] == up_pc.fields.tag_bits);
		end
	end

	assign lk_way = ~lk_hit[0];	// way 0 wins if both somehow match

	// prediction, fall-through unless a valid frame says taken
	assign pred_taken = (|lk_hit) && taken_q[lk_pc.fields.idx_bits][lk_way];
	assign pred_target = pred_taken ? target_q[lk_pc.fields.idx_bits][lk_way]
		: lookup_pc + INSTR_BYTES;

	// victim choice: matching frame, then a free frame, then LRU
	always_comb begin
		if (|up_hit) begin
			up_way = ~up_hit[0];
		end else if (!valid_q[up_pc.fields.idx_bits][0]) begin
			up_way = 1'b0;
		end else if (!valid_q[up_pc.fields.idx_bits][1]) begin
			up_way = 1'b1;
		end else begin
			up_way = lru_q[up_pc.fields.idx_bits];
		end
	end

	// valid and LRU state
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < N_SETS; s++) begin
				valid_q[s] <= '0;	// table starts empty
				lru_q[s] <= 1'b0;
			end
		end else begin
			if (|lk_hit)
				lru_q[lk_pc.fields.idx_bits] <= ~lk_way;	// point away from used frame
			// update comes last so it wins a same-set collision
			if (upd_valid) begin
				valid_q[up_pc.fields.idx_bits][up_way] <= 1'b1;
				lru_q[up_pc.fields.idx_bits] <= ~up_way;
			end
		end
	end

	// frame payload
	always_ff @(posedge CLK) begin
		if (upd_valid) begin
			tag_q[up_pc.fields.idx_bits][up_way] <= up_pc.fields.tag_bits;
			target_q[up_pc.fields.idx_bits][up_way] <= upd_target;
			taken_q[up_pc.fields.idx_bits][up_way] <= upd_taken;
		end
	end

endmodule

// ==== design/bp_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths and geometry for the next-PC predictor
// RV32 without compressed instructions, so every fetch is 4 bytes
// BTB tag covers 7 PC bits only; the upper 19 bits alias freely
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package bp_pkg;

	localparam int WORD_SIZE = 32;	// instruction address width

	typedef logic [WORD_SIZE-1:0] word_t;

	// BTB geometry
	localparam int N_FRAMES = 32;
	localparam int ASSOC = 2;	// way select logic is written for 2 ways
	localparam int N_SETS = N_FRAMES / ASSOC;
	localparam int N_TAG_BITS = 7;
	localparam int N_SET_BITS = $clog2(N_SETS);	// 4
	localparam int N_BYTE_BITS = 2;	// word aligned fetch
	localparam int N_IGNORE_BITS = WORD_SIZE - N_TAG_BITS - N_SET_BITS - N_BYTE_BITS;

	// fetch queue sizing, depth must stay a power of two
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_BITS = $clog2(QUEUE_DEPTH + 1);	// holds 0..DEPTH

	// first fetch address after reset
	localparam word_t RESET_PC = 32'h0000_0100;

	// fall-through step
	localparam word_t INSTR_BYTES = 32'd4;

	// one PC, two readings: plain word for adders, split fields for BTB indexing
	typedef union packed {
		word_t raw;
		struct packed {
			logic [N_IGNORE_BITS-1:0] ignore_bits;	// not compared
			logic [N_TAG_BITS-1:0] tag_bits;
			logic [N_SET_BITS-1:0] idx_bits;
			logic [N_BYTE_BITS-1:0] byte_bits;	// always 0 for aligned PCs
		} fields;
	} pc_view_t;

endpackage
